/* vlog.f */
mouse_pkg.sv
ps2_cmd_if.sv
ps2_line_filter.sv
ps2_host_tx.sv
ps2_host_rx.sv
mouse_ctrl.sv
cursor_tracker.sv
wb_mouse_regs.sv
mouse_top.sv
ps2_device_model.sv
tb_mouse_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mouse_top -f vlog.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_mouse_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

/* tb_mouse_top.sv */
`timescale 1ns/10ps

module tb_mouse_top import mouse_pkg::*; ();

  localparam int X_MAX          = 410;
  localparam int Y_MAX          = 308;
  localparam int X_CENTRE       = 204;
  localparam int Y_CENTRE       = 153;
  localparam int INHIBIT_CYCLES = 200;
  localparam int FILTER_LEN     = 4;
  localparam int NUM_PACKETS    = 20;
  localparam int FRAME_CYCLES   = 11 * 20 + 20;
  // command, two bytes before ready, the packets and the error test.
  localparam int NUM_FRAMES     = 1 + 2 + 3 * NUM_PACKETS + 5;
  localparam int TIMEOUT_CYCLES = 2 * (INHIBIT_CYCLES + NUM_FRAMES * FRAME_CYCLES);

  logic             clk;
  logic             rst      = 1'b1;
  logic             wb_cyc   = 1'b0;
  logic             wb_stb   = 1'b0;
  logic             wb_we    = 1'b0;
  logic [1:0]       wb_adr   = 2'd0;
  logic [POS_W-1:0] wb_dat_w = '0;
  logic [POS_W-1:0] wb_dat_r;
  logic             wb_ack;
  logic             ps2_clk_in;
  logic             ps2_data_in;
  logic             ps2_clk_pull;
  logic             ps2_data_pull;

  integer     seed;
  int         cycle_cnt = 0;
  int         exp_x;
  int         exp_y;
  logic [2:0] exp_btn;

  mouse_top #(
    .X_MAX(X_MAX), .Y_MAX(Y_MAX), .X_CENTRE(X_CENTRE), .Y_CENTRE(Y_CENTRE),
    .INHIBIT_CYCLES(INHIBIT_CYCLES), .FILTER_LEN(FILTER_LEN)
  ) mouse_top_i (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in),
    .ps2_clk_pull(ps2_clk_pull), .ps2_data_pull(ps2_data_pull)
  );

  ps2_device_model device_i (
    .clk(clk), .host_clk_pull(ps2_clk_pull), .host_data_pull(ps2_data_pull),
    .clk_line(ps2_clk_in), .data_line(ps2_data_in)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) fail_run("timeout, the tests did not finish in time");
  end

  // wishbone classic: one ack per access, one cycle after the strobe.
  assert property (@(posedge clk) disable iff (rst) $past(wb_ack) |-> !wb_ack)
    else fail_run("wishbone ack stayed high for two cycles");
  assert property (@(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb))
    else fail_run("wishbone ack came without an active cycle");
  assert property (@(posedge clk) disable iff (rst)
                   $past(wb_cyc && wb_stb && !wb_ack) |-> wb_ack)
    else fail_run("wishbone ack did not follow the strobe by one cycle");

  task automatic expect_equal(input string name, input int got, input int exp);
    assert (got == exp)
      else fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                              $time, name, got, exp));
  endtask

  task automatic bus_read(input reg_addr_t adr, output logic [POS_W-1:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);
    data = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic bus_write(input reg_addr_t adr, input logic [POS_W-1:0] data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic read_expect(input reg_addr_t adr, input string name, input int exp);
    logic [POS_W-1:0] data;
    bus_read(adr, data);
    expect_equal(name, int'(data), exp);
  endtask

  function automatic int clamp_ref(input int value, input int max);
    if (value < 0) return 0;
    if (value > max) return max;
    return value;
  endfunction

  function automatic int step_value(input logic sign, input logic [7:0] mag);
    return sign ? int'(mag) - 256 : int'(mag);
  endfunction

  task automatic check_position();
    read_expect(REG_POS_X, "REG_POS_X", exp_x);
    read_expect(REG_POS_Y, "REG_POS_Y", exp_y);
    read_expect(REG_STATUS, "REG_STATUS", int'(exp_btn));
  endtask

  // screen rows grow downward, so positive dy moves the cursor up.
  task automatic send_packet(input logic [2:0] btn, input logic xs, input logic [7:0] dx,
                             input logic ys, input logic [7:0] dy);
    device_i.send_frame({2'b00, ys, xs, 1'b1, btn}, 1'b0);
    device_i.send_frame(dx, 1'b0);
    device_i.send_frame(dy, 1'b0);
    exp_x   = clamp_ref(exp_x + step_value(xs, dx), X_MAX);
    exp_y   = clamp_ref(exp_y - step_value(ys, dy), Y_MAX);
    exp_btn = btn;
    check_position();
  endtask

  task automatic wait_until_ready();
    logic [POS_W-1:0] flags;
    int               polls;
    flags = '0;
    polls = 0;
    while (!flags[0] && polls < 8) begin
      bus_read(REG_FLAGS, flags);
      polls++;
    end
    expect_equal("REG_FLAGS", int'(flags), 1);
  endtask

  initial begin
    logic [7:0]  cmd_byte;
    logic        start_ok;
    logic        parity_ok;
    logic        stop_ok;
    int          inhibit_len;
    logic [31:0] r;
    int          i;
    seed    = 32'hb9429497;
    exp_x   = X_CENTRE;
    exp_y   = Y_CENTRE;
    exp_btn = 3'b000;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    fork
      device_i.receive_command(cmd_byte, start_ok, parity_ok, stop_ok, inhibit_len);
      begin
        read_expect(REG_POS_X, "REG_POS_X", X_CENTRE);
        read_expect(REG_POS_Y, "REG_POS_Y", Y_CENTRE);
        read_expect(REG_FLAGS, "REG_FLAGS", 0);
      end
    join
    expect_equal("command byte", int'(cmd_byte), 8'hF4);
    expect_equal("clock inhibit length", inhibit_len, INHIBIT_CYCLES);
    assert (start_ok) else fail_run("host did not hold data low for the start bit");
    assert (parity_ok) else fail_run("command frame does not have odd parity");
    assert (stop_ok) else fail_run("command frame stop bit was low");

    device_i.send_frame(8'h55, 1'b0); // not an acknowledge.
    read_expect(REG_FLAGS, "REG_FLAGS", 0);
    device_i.send_frame(ACK_BYTE, 1'b0);
    wait_until_ready();

    send_packet(3'b001, 1'b0, 8'hFF, 1'b1, 8'h00); // both axes hit their maximum.
    send_packet(3'b010, 1'b0, 8'hFF, 1'b0, 8'h00);
    send_packet(3'b100, 1'b1, 8'h00, 1'b0, 8'hFF);
    send_packet(3'b011, 1'b1, 8'h00, 1'b0, 8'hFF); // both axes end at zero.
    for (i = 4; i < NUM_PACKETS; i++) begin
      r = $random(seed);
      send_packet(r[20:18], r[16], r[7:0], r[17], r[15:8]);
    end

    // the packet breaks at its x byte, so the FSM must resynchronise.
    device_i.send_frame(8'b0000_1111, 1'b0);
    device_i.send_frame(8'h40, 1'b1);
    read_expect(REG_FLAGS, "REG_FLAGS", 3);
    read_expect(REG_FLAGS, "REG_FLAGS", 1);
    send_packet(3'b101, 1'b0, 8'd25, 1'b1, 8'hF0);

    bus_write(REG_POS_X, 16'd500);
    read_expect(REG_POS_X, "REG_POS_X", X_MAX);
    bus_write(REG_POS_Y, 16'd20);
    read_expect(REG_POS_Y, "REG_POS_Y", 20);

    $display("Test OK");
    $finish;
  end

endmodule

/* ps2_device_model.sv */
`timescale 1ns/10ps

module ps2_device_model #(
  parameter int HALF_CYCLES = 10
) (
  input  logic clk,
  input  logic host_clk_pull,
  input  logic host_data_pull,
  output logic clk_line,
  output logic data_line
);

  logic dev_clk_pull  = 1'b0;
  logic dev_data_pull = 1'b0;

  // open-drain bus, whoever pulls wins.
  assign clk_line  = !(host_clk_pull || dev_clk_pull);
  assign data_line = !(host_data_pull || dev_data_pull);

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one device clock pulse; host data is read just before the clock rises.
  task automatic clock_pulse(output logic sampled);
    dev_clk_pull <= 1'b1;
    wait_cycles(HALF_CYCLES);
    sampled = data_line;
    dev_clk_pull <= 1'b0;
    wait_cycles(HALF_CYCLES);
  endtask

  task automatic receive_command(output logic [7:0] data, output logic start_ok,
                                 output logic parity_ok, output logic stop_ok,
                                 output int inhibit_len);
    logic [9:0] bits;
    logic       bit_val;
    int         i;
    inhibit_len = 0;
    @(posedge clk);
    while (!host_clk_pull) @(posedge clk);
    while (host_clk_pull) begin
      inhibit_len++;
      @(posedge clk);
    end
    wait_cycles(2 * HALF_CYCLES); // the host filter needs a steady high clock first.
    start_ok = !data_line;
    for (i = 0; i < 10; i++) begin
      clock_pulse(bit_val);
      bits[i] = bit_val;
    end
    dev_data_pull <= 1'b1; // line acknowledge.
    clock_pulse(bit_val);
    dev_data_pull <= 1'b0;
    data      = bits[7:0];
    parity_ok = ^bits[8:0];
    stop_ok   = bits[9];
  endtask

  // the host samples on the falling edge, so data settles half a phase before it.
  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < 11; i++) begin
      dev_data_pull <= !frame[i];
      wait_cycles(HALF_CYCLES / 2);
      dev_clk_pull <= 1'b1;
      wait_cycles(HALF_CYCLES);
      dev_clk_pull <= 1'b0;
      wait_cycles(HALF_CYCLES / 2);
    end
    dev_data_pull <= 1'b0;
    wait_cycles(2 * HALF_CYCLES); // idle gap between frames.
  endtask

endmodule

/* mouse_top.sv */
`timescale 1ns/10ps

module mouse_top import mouse_pkg::*; #(
  parameter int X_MAX          = 410,
  parameter int Y_MAX          = 308,
  parameter int X_CENTRE       = 204,
  parameter int Y_CENTRE       = 153,
  parameter int INHIBIT_CYCLES = 10000,
  parameter int FILTER_LEN     = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [1:0]       wb_adr,
  input  logic [POS_W-1:0] wb_dat_w,
  output logic [POS_W-1:0] wb_dat_r,
  output logic             wb_ack,
  input  logic             ps2_clk_in,
  input  logic             ps2_data_in,
  output logic             ps2_clk_pull,
  output logic             ps2_data_pull
);

  logic             clk_fall;
  logic             data_sync;
  logic [7:0]       rx_byte;
  logic             rx_valid;
  logic             rx_err;
  mouse_packet_t    pkt;
  logic             pkt_valid;
  logic             ready;
  logic             err_pulse;
  logic [2:0]       last_buttons;
  logic             load_x;
  logic             load_y;
  logic [POS_W-1:0] load_data;
  logic [POS_W-1:0] pos_x;
  logic [POS_W-1:0] pos_y;

  ps2_cmd_if cmd_bus ();

  ps2_line_filter #(.FILTER_LEN(FILTER_LEN)) line_filter_i (
    .clk(clk), .rst(rst), .clk_in(ps2_clk_in), .data_in(ps2_data_in),
    .clk_fall(clk_fall), .clk_rise(), .data_sync(data_sync)
  );

  ps2_host_tx #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) host_tx_i (
    .clk(clk), .rst(rst), .clk_fall(clk_fall), .data_sync(data_sync),
    .cmd(cmd_bus.tx_mp), .clk_pull(ps2_clk_pull), .data_pull(ps2_data_pull)
  );

  // the receiver stays deaf to the host's own frame.
  ps2_host_rx host_rx_i (
    .clk(clk), .rst(rst), .clk_fall(clk_fall), .data_sync(data_sync),
    .enable(!cmd_bus.busy), .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_err(rx_err)
  );

  mouse_ctrl ctrl_i (
    .clk(clk), .rst(rst), .cmd(cmd_bus.ctrl_mp), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .rx_err(rx_err), .pkt(pkt), .pkt_valid(pkt_valid), .ready(ready),
    .err_pulse(err_pulse), .last_buttons(last_buttons)
  );

  cursor_tracker #(
    .X_MAX(X_MAX), .Y_MAX(Y_MAX), .X_CENTRE(X_CENTRE), .Y_CENTRE(Y_CENTRE)
  ) tracker_i (
    .clk(clk), .rst(rst), .pkt(pkt), .pkt_valid(pkt_valid), .load_x(load_x),
    .load_y(load_y), .load_data(load_data), .pos_x(pos_x), .pos_y(pos_y)
  );

  wb_mouse_regs regs_i (
    .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
    .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack), .pos_x(pos_x), .pos_y(pos_y),
    .buttons(last_buttons), .ready(ready), .err_pulse(err_pulse), .load_x(load_x),
    .load_y(load_y), .load_data(load_data)
  );

endmodule

/* wb_mouse_regs.sv */
`timescale 1ns/10ps

module wb_mouse_regs import mouse_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [1:0]       adr,
  input  logic [POS_W-1:0] dat_w,
  output logic [POS_W-1:0] dat_r,
  output logic             ack,
  input  logic [POS_W-1:0] pos_x,
  input  logic [POS_W-1:0] pos_y,
  input  logic [2:0]       buttons,
  input  logic             ready,
  input  logic             err_pulse,
  output logic             load_x,
  output logic             load_y,
  output logic [POS_W-1:0] load_data
);

  logic req;
  logic err_flag;

  assign req = cyc && stb && !ack; // one wait state, never two acks in a row.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack      <= 1'b0;
      err_flag <= 1'b0;
    end else begin
      ack <= req;
      if (err_pulse) err_flag <= 1'b1;
      else if (req && !we && adr == REG_FLAGS) err_flag <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      case (reg_addr_t'(adr))
        REG_STATUS: dat_r <= {{(POS_W-3){1'b0}}, buttons};
        REG_POS_X:  dat_r <= pos_x;
        REG_POS_Y:  dat_r <= pos_y;
        default:    dat_r <= {{(POS_W-2){1'b0}}, err_flag, ready};
      endcase
    end
  end

  // master still holds the write cycle while ack is high.
  assign load_x    = ack && we && (adr == REG_POS_X);
  assign load_y    = ack && we && (adr == REG_POS_Y);
  assign load_data = dat_w;

endmodule

/* cursor_tracker.sv */
`timescale 1ns/10ps

module cursor_tracker import mouse_pkg::*; #(
  parameter int X_MAX    = 410,
  parameter int Y_MAX    = 308,
  parameter int X_CENTRE = 204,
  parameter int Y_CENTRE = 153
) (
  input  logic             clk,
  input  logic             rst,
  input  mouse_packet_t    pkt,
  input  logic             pkt_valid,
  input  logic             load_x,
  input  logic             load_y,
  input  logic [POS_W-1:0] load_data,
  output logic [POS_W-1:0] pos_x,
  output logic [POS_W-1:0] pos_y
);

  localparam int SUM_W = POS_W + 2;

  logic signed [SUM_W-1:0] step_x;
  logic signed [SUM_W-1:0] step_y;
  logic signed [SUM_W-1:0] sum_x;
  logic signed [SUM_W-1:0] sum_y;

  function automatic logic [POS_W-1:0] clamp(input logic signed [SUM_W-1:0] v, input int max);
    if (v < 0) return '0;
    if (v >= max) return POS_W'(max);
    return v[POS_W-1:0];
  endfunction

  assign step_x = $signed({pkt.x_sign, pkt.dx});
  assign step_y = $signed({pkt.y_sign, pkt.dy});
  assign sum_x  = $signed({2'b00, pos_x}) + step_x;
  assign sum_y  = $signed({2'b00, pos_y}) - step_y; // mouse up moves toward row 0.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos_x <= POS_W'(X_CENTRE);
      pos_y <= POS_W'(Y_CENTRE);
    end else begin
      if (load_x) pos_x <= clamp({2'b00, load_data}, X_MAX);
      else if (pkt_valid) pos_x <= clamp(sum_x, X_MAX);
      if (load_y) pos_y <= clamp({2'b00, load_data}, Y_MAX);
      else if (pkt_valid) pos_y <= clamp(sum_y, Y_MAX);
    end
  end

endmodule

/* mouse_ctrl.sv */
`timescale 1ns/10ps

module mouse_ctrl import mouse_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  ps2_cmd_if.ctrl_mp    cmd,
  input  logic [7:0]    rx_byte,
  input  logic          rx_valid,
  input  logic          rx_err,
  output mouse_packet_t pkt,
  output logic          pkt_valid,
  output logic          ready,
  output logic          err_pulse,
  output logic [2:0]    last_buttons
);

  ctrl_state_t state;

  assign cmd.cmd = CMD_ENABLE_STREAM;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= ST_RESET;
      cmd.start    <= 1'b0;
      pkt_valid    <= 1'b0;
      ready        <= 1'b0;
      err_pulse    <= 1'b0;
      last_buttons <= '0;
    end else begin
      cmd.start <= 1'b0;
      pkt_valid <= 1'b0;
      err_pulse <= rx_err;
      case (state)
        ST_RESET: begin
          if (!cmd.busy) begin
            cmd.start <= 1'b1;
            state     <= ST_SEND_ENABLE;
          end
        end
        ST_SEND_ENABLE: begin
          if (cmd.done) state <= cmd.line_ack ? ST_WAIT_ACK : ST_RESET; // no line ack, send again.
        end
        ST_WAIT_ACK: begin
          if (rx_valid && rx_byte == ACK_BYTE) begin
            ready <= 1'b1;
            state <= ST_BUTTON;
          end
        end
        ST_BUTTON: if (rx_valid) state <= ST_XMOVE;
        ST_XMOVE: begin
          if (rx_err) state <= ST_BUTTON;
          else if (rx_valid) state <= ST_YMOVE;
        end
        ST_YMOVE: begin
          if (rx_err) begin
            state <= ST_BUTTON;
          end else if (rx_valid) begin
            pkt_valid    <= 1'b1;
            last_buttons <= pkt.buttons;
            state        <= ST_BUTTON;
          end
        end
        default: state <= ST_RESET;
      endcase
    end
  end

  // first byte is {y ovf, x ovf, y sign, x sign, 1, middle, right, left}.
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        ST_BUTTON: begin
          pkt.buttons <= rx_byte[2:0];
          pkt.x_sign  <= rx_byte[4];
          pkt.y_sign  <= rx_byte[5];
        end
        ST_XMOVE: pkt.dx <= rx_byte;
        ST_YMOVE: pkt.dy <= rx_byte;
        default: ;
      endcase
    end
  end

endmodule

/* ps2_host_rx.sv */
`timescale 1ns/10ps

module ps2_host_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       clk_fall,
  input  logic       data_sync,
  input  logic       enable,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       rx_err
);

  typedef enum logic {
    RX_IDLE,
    RX_FRAME
  } rx_state_t;

  rx_state_t   state;
  logic [3:0]  bit_cnt;
  logic [10:0] frame;
  logic [10:0] frame_next;
  logic        frame_ok;
  logic        start_seen;
  logic        last_bit;

  assign frame_next = {data_sync, frame[10:1]};
  assign start_seen = (state == RX_IDLE) && clk_fall && enable && !data_sync;
  assign last_bit   = (state == RX_FRAME) && clk_fall && (bit_cnt == 4'd10);

  // start low, odd parity over data and parity, stop high.
  assign frame_ok = !frame_next[0] && (^frame_next[9:1]) && frame_next[10];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      if (start_seen) begin
        bit_cnt <= 4'd1;
        state   <= RX_FRAME;
      end else if (last_bit) begin
        rx_valid <= frame_ok;
        rx_err   <= !frame_ok;
        state    <= RX_IDLE;
      end else if (state == RX_FRAME && clk_fall) begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_seen || (state == RX_FRAME && clk_fall)) frame <= frame_next;
    if (last_bit) rx_byte <= frame_next[8:1];
  end

endmodule

/* ps2_host_tx.sv */
`timescale 1ns/10ps

module ps2_host_tx #(
  parameter int INHIBIT_CYCLES = 10000
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     clk_fall,
  input  logic     data_sync,
  ps2_cmd_if.tx_mp cmd,
  output logic     clk_pull,
  output logic     data_pull
);

  localparam int CNT_W = $clog2(INHIBIT_CYCLES + 1);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_INHIBIT,
    TX_START,
    TX_BITS,
    TX_PARITY,
    TX_STOP,
    TX_LINE_ACK
  } tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] hold_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;
  logic             parity;
  logic             ack_bit;
  logic             accept;

  // the done cycle counts as idle, busy is already low there.
  assign accept = cmd.start && (state == TX_IDLE || state == TX_LINE_ACK);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= TX_IDLE;
      hold_cnt <= '0;
      bit_cnt  <= '0;
      ack_bit  <= 1'b0;
    end else begin
      case (state)
        TX_IDLE, TX_LINE_ACK: begin
          hold_cnt <= CNT_W'(INHIBIT_CYCLES - 1);
          state    <= accept ? TX_INHIBIT : TX_IDLE;
        end
        TX_INHIBIT: begin
          if (hold_cnt == '0) state <= TX_START;
          else hold_cnt <= hold_cnt - 1'b1;
        end
        TX_START: begin
          bit_cnt <= '0;
          if (clk_fall) state <= TX_BITS; // first device clock, present bit 0.
        end
        TX_BITS: begin
          if (clk_fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= TX_PARITY;
          end
        end
        TX_PARITY: if (clk_fall) state <= TX_STOP;
        TX_STOP: begin
          if (clk_fall) begin
            ack_bit <= ~data_sync; // device holds data low to acknowledge.
            state   <= TX_LINE_ACK;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      shreg  <= cmd.cmd;
      parity <= ~^cmd.cmd;
    end else if (state == TX_BITS && clk_fall) begin
      shreg <= {1'b1, shreg[7:1]};
    end
  end

  always_comb begin
    case (state)
      TX_START:  data_pull = 1'b1;
      TX_BITS:   data_pull = ~shreg[0];
      TX_PARITY: data_pull = ~parity;
      default:   data_pull = 1'b0;
    endcase
  end

  assign clk_pull     = (state == TX_INHIBIT);
  assign cmd.busy     = (state != TX_IDLE) && (state != TX_LINE_ACK);
  assign cmd.done     = (state == TX_LINE_ACK);
  assign cmd.line_ack = ack_bit;

endmodule

/* ps2_line_filter.sv */
`timescale 1ns/10ps

module ps2_line_filter #(
  parameter int FILTER_LEN = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic clk_in,
  input  logic data_in,
  output logic clk_fall,
  output logic clk_rise,
  output logic data_sync
);

  logic [1:0]              clk_meta;
  logic [1:0]              data_meta;
  logic [2*FILTER_LEN-1:0] clk_hist;

  // lines idle high, so everything resets to one.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_meta  <= 2'b11;
      data_meta <= 2'b11;
      clk_hist  <= '1;
    end else begin
      clk_meta  <= {clk_meta[0], clk_in};
      data_meta <= {data_meta[0], data_in};
      clk_hist  <= {clk_hist[2*FILTER_LEN-2:0], clk_meta[1]}; // newest sample in bit 0.
    end
  end

  assign clk_fall  = (clk_hist[2*FILTER_LEN-1:FILTER_LEN] == '1) &&
                     (clk_hist[FILTER_LEN-1:0] == '0);
  assign clk_rise  = (clk_hist[2*FILTER_LEN-1:FILTER_LEN] == '0) &&
                     (clk_hist[FILTER_LEN-1:0] == '1);
  assign data_sync = data_meta[1];

endmodule

/* ps2_cmd_if.sv */
`timescale 1ns/10ps

interface ps2_cmd_if import mouse_pkg::*; ();

  logic     start;    // one-cycle request, only while busy is low.
  ps2_cmd_t cmd;
  logic     busy;
  logic     done;     // one-cycle pulse at the end of the frame.
  logic     line_ack; // valid with done.

  modport ctrl_mp (
    output start, cmd,
    input  busy, done, line_ack
  );

  modport tx_mp (
    input  start, cmd,
    output busy, done, line_ack
  );

endinterface

/* mouse_pkg.sv */
package mouse_pkg;

  localparam int POS_W = 16; // cursor coordinate width.

  typedef enum logic [2:0] {
    ST_RESET,
    ST_SEND_ENABLE,
    ST_WAIT_ACK,
    ST_BUTTON,
    ST_XMOVE,
    ST_YMOVE
  } ctrl_state_t;

  // only stream enable is sent to the mouse.
  typedef enum logic [7:0] {
    CMD_ENABLE_STREAM = 8'hF4
  } ps2_cmd_t;

  localparam logic [7:0] ACK_BYTE = 8'hFA;

  typedef struct packed {
    logic [2:0] buttons; // middle, right, left.
    logic       x_sign;
    logic       y_sign;
    logic [7:0] dx;
    logic [7:0] dy;
  } mouse_packet_t;

  typedef enum logic [1:0] {
    REG_STATUS = 2'd0,
    REG_POS_X  = 2'd1,
    REG_POS_Y  = 2'd2,
    REG_FLAGS  = 2'd3
  } reg_addr_t;

endpackage
